/* vlog.f */
design/lamb_pkg.sv
design/latch_block.sv
design/lamb_array.sv
design/lamb_port_ctrl.sv
design/latch_array_top.sv
tb/tb_latch_array.sv

/* Makefile */
# Verilator build and run of the latch array testbench

VERILATOR  ?= verilator
TOP        := tb_latch_array
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Regression failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_latch_array.sv */
// testbench for the latch array memory bank
// random writes, reads and response back-pressure from a fixed-seed LFSR,
// checked against a row model and a queue of expected read data

`timescale 1ns/1ps

module tb_latch_array;

   // ------------------------------------------------------------------------
   // DUT signals and testbench state
   // ------------------------------------------------------------------------

   logic              clk;
   logic              rst;
   logic              wr_valid;
   logic              wr_ready;
   lamb_pkg::wr_req_t wr_req;
   logic              rd_valid;
   logic              rd_ready;
   lamb_pkg::rd_req_t rd_req;
   logic              rsp_valid;
   logic              rsp_ready;
   lamb_pkg::data_t   rsp_data;

   // row model and the read data still owed by the DUT, oldest first
   lamb_pkg::data_t model [lamb_pkg::lamb_depth];
   lamb_pkg::data_t exp_q [$];
   int              acc_q [$];

   logic [15:0]     lfsr;
   int              cyc;
   int              err_value;
   int              err_other;
   int              n_rsp;
   logic            wr_acc;
   logic            rd_acc;
   logic            lat_chk;
   logic            held;
   lamb_pkg::data_t held_data;
   int              coll_rows [6] = '{0, 15, 16, 31, 32, 39};

   latch_array_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .wr_valid  (wr_valid),
      .wr_ready  (wr_ready),
      .wr_req    (wr_req),
      .rd_valid  (rd_valid),
      .rd_ready  (rd_ready),
      .rd_req    (rd_req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------

   // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic lamb_pkg::addr_t rand_addr();
      return lamb_pkg::addr_t'(rand_bits(6) % lamb_pkg::lamb_depth);
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      err_value++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
   endtask

   task automatic report_other(input string what);
      err_other++;
      $display("Error at %0t: %s", $time, what);
   endtask

   // pops the oldest expected word and compares it with the response on the bus
   task automatic take_response();
      lamb_pkg::data_t exp;
      int              acc;
      if (exp_q.size() == 0)
      begin
         report_other("response returned with no read outstanding");
      end
      else
      begin
         exp = exp_q.pop_front();
         acc = acc_q.pop_front();
         n_rsp++;
         assert (rsp_data == exp)
            else report_value("rsp_data", 32'(rsp_data), 32'(exp));
         if (lat_chk)
         begin
            assert (cyc - acc == 2)
               else report_other($sformatf("read latency of %0d edges, expected 2",
                                           cyc - acc));
         end
      end
   endtask

   // looks at the bus just before the rising edge and records what transfers on it
   task automatic observe();
      wr_acc = wr_valid && wr_ready;
      rd_acc = rd_valid && rd_ready;
      if (held)
      begin
         assert (rsp_valid)
            else report_other("held response dropped before it was taken");
         assert (rsp_data == held_data)
            else report_value("rsp_data", 32'(rsp_data), 32'(held_data));
      end
      held      = rsp_valid && !rsp_ready;
      held_data = rsp_data;
      if (rsp_valid && rsp_ready)
      begin
         take_response();
      end
      // the read sees the row as left by writes of earlier edges only
      if (rd_acc)
      begin
         exp_q.push_back(model[rd_req.addr]);
         acc_q.push_back(cyc);
      end
      if (wr_acc)
      begin
         model[wr_req.addr] = wr_req.data;
      end
      cyc++;
   endtask

   // one clock cycle, returning 1 ns after the rising edge
   task automatic cycle();
      @(negedge clk);
      observe();
      @(posedge clk);
      #1;
   endtask

   task automatic write_row(input lamb_pkg::addr_t a, input lamb_pkg::data_t d);
      int t;
      wr_valid     = 1'b1;
      wr_req.addr  = a;
      wr_req.data  = d;
      t = 0;
      do
      begin
         cycle();
         t++;
      end
      while (!wr_acc && t < 50);
      if (!wr_acc)
      begin
         report_other($sformatf("write to row %0d never accepted", a));
      end
      wr_valid = 1'b0;
   endtask

   // lets pending requests finish and collects every outstanding response
   task automatic drain();
      int t;
      t = 0;
      rsp_ready = 1'b1;
      if (wr_acc)
         wr_valid = 1'b0;
      if (rd_acc)
         rd_valid = 1'b0;
      while ((wr_valid || rd_valid || exp_q.size() != 0) && t < 100)
      begin
         cycle();
         if (wr_acc)
            wr_valid = 1'b0;
         if (rd_acc)
            rd_valid = 1'b0;
         t++;
      end
      if (wr_valid || rd_valid || exp_q.size() != 0)
      begin
         report_other($sformatf("drain timed out with %0d reads outstanding",
                                exp_q.size()));
      end
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------

   initial
   begin
      int start;
      int t;
      lamb_pkg::data_t d;
      rst       = 1'b1;
      wr_valid  = 1'b0;
      wr_req    = '0;
      rd_valid  = 1'b0;
      rd_req    = '0;
      rsp_ready = 1'b1;
      lfsr      = 16'd36116;
      cyc       = 0;
      err_value = 0;
      err_other = 0;
      n_rsp     = 0;
      wr_acc    = 1'b0;
      rd_acc    = 1'b0;
      lat_chk   = 1'b1;
      held      = 1'b0;
      held_data = '0;
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;

      // idle port straight out of reset
      @(negedge clk);
      assert (!rsp_valid) else report_value("rsp_valid", 32'(rsp_valid), 32'd0);
      assert (wr_ready) else report_value("wr_ready", 32'(wr_ready), 32'd1);
      assert (rd_ready) else report_value("rd_ready", 32'(rd_ready), 32'd1);
      @(posedge clk);
      #1;

      // every row gets a known word before any read
      for (int a = 0; a < lamb_pkg::lamb_depth; a++)
      begin
         write_row(lamb_pkg::addr_t'(a), lamb_pkg::data_t'(rand_bits(lamb_pkg::lamb_width)));
      end

      // back-to-back sweep over all rows, one read accepted per cycle
      start = cyc;
      for (int a = 0; a < lamb_pkg::lamb_depth; a++)
      begin
         rd_valid    = 1'b1;
         rd_req.addr = lamb_pkg::addr_t'(a);
         t = 0;
         do
         begin
            cycle();
            t++;
         end
         while (!rd_acc && t < 50);
         if (!rd_acc)
            report_other($sformatf("read of row %0d never accepted", a));
      end
      rd_valid = 1'b0;
      assert (cyc - start == lamb_pkg::lamb_depth)
         else report_other($sformatf("sweep of %0d reads took %0d cycles",
                                     lamb_pkg::lamb_depth, cyc - start));
      drain();

      // mixed traffic with random back-pressure, latency varies here
      lat_chk = 1'b0;
      for (int i = 0; i < 400; i++)
      begin
         if (!wr_valid || wr_acc)
         begin
            wr_valid    = rand_bits(1) == 1;
            wr_req.addr = rand_addr();
            wr_req.data = lamb_pkg::data_t'(rand_bits(lamb_pkg::lamb_width));
         end
         if (!rd_valid || rd_acc)
         begin
            rd_valid    = rand_bits(1) == 1;
            rd_req.addr = rand_addr();
         end
         rsp_ready = rand_bits(2) != 0;
         cycle();
      end
      drain();
      lat_chk = 1'b1;

      // same row on both ports in one cycle, at the block edges
      foreach (coll_rows[i])
      begin
         d           = lamb_pkg::data_t'(rand_bits(lamb_pkg::lamb_width));
         wr_valid    = 1'b1;
         wr_req.addr = lamb_pkg::addr_t'(coll_rows[i]);
         wr_req.data = d;
         rd_valid    = 1'b1;
         rd_req.addr = lamb_pkg::addr_t'(coll_rows[i]);
         cycle();
         assert (wr_acc && !rd_acc)
            else report_other($sformatf("collision on row %0d not ordered write first",
                                        coll_rows[i]));
         drain();
      end

      $display("errors: %0d value, %0d other, %0d responses checked",
               err_value, err_other, n_rsp);
      if (err_value == 0 && err_other == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* design/latch_array_top.sv */
// latch array top level
// port controller in front of the 40 x 24 latch array memory bank

`timescale 1ns/1ps

module latch_array_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                wr_valid,
   output logic                wr_ready,
   input  lamb_pkg::wr_req_t   wr_req,
   input  logic                rd_valid,
   output logic                rd_ready,
   input  lamb_pkg::rd_req_t   rd_req,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output lamb_pkg::data_t     rsp_data
);

   // accepted requests towards the array
   logic            wen;
   lamb_pkg::addr_t wadr;
   lamb_pkg::data_t wdata;
   logic            ren;
   lamb_pkg::addr_t radr;

   // read word from the array stage
   lamb_pkg::data_t dout;

   lamb_port_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .wr_valid  (wr_valid),
      .wr_ready  (wr_ready),
      .wr_req    (wr_req),
      .rd_valid  (rd_valid),
      .rd_ready  (rd_ready),
      .rd_req    (rd_req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .wen       (wen),
      .wadr      (wadr),
      .wdata     (wdata),
      .ren       (ren),
      .radr      (radr),
      .dout      (dout)
   );

   lamb_array u_array (
      .clk   (clk),
      .rst   (rst),
      .wen   (wen),
      .wadr  (wadr),
      .wdata (wdata),
      .ren   (ren),
      .radr  (radr),
      .dout  (dout)
   );

endmodule

/* design/lamb_port_ctrl.sv */
// port controller for the latch array
// accepts writes and reads with valid/ready, holds back a read that hits the
// row being written, and returns read data through a response register

`timescale 1ns/1ps

module lamb_port_ctrl (
   input  logic                clk,
   input  logic                rst,
   // write request
   input  logic                wr_valid,
   output logic                wr_ready,
   input  lamb_pkg::wr_req_t   wr_req,
   // read request
   input  logic                rd_valid,
   output logic                rd_ready,
   input  lamb_pkg::rd_req_t   rd_req,
   // read response
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output lamb_pkg::data_t     rsp_data,
   // array side
   output logic                wen,
   output lamb_pkg::addr_t     wadr,
   output lamb_pkg::data_t     wdata,
   output logic                ren,
   output lamb_pkg::addr_t     radr,
   input  lamb_pkg::data_t     dout
);

   // a read sits in the array stage and its data is on dout this cycle
   logic stage_vld;

   // the array stage holds a read that has nowhere to go
   logic stall;

   // read and write target the same row in the same cycle
   logic collision;

   // the array stage moves its read into the response register
   logic adv;

   // --------------------------------------------------------------------------
   // acceptance
   // --------------------------------------------------------------------------

   // a full response register that is not being drained blocks the stage,
   // but only if the stage actually holds a read
   assign stall = stage_vld && rsp_valid && !rsp_ready;

   assign collision = wr_valid && rd_valid && (wr_req.addr == rd_req.addr);

   // writes are held off during a stall so the row under the stalled read
   // cannot change before its data is captured
   assign wr_ready = !stall;

   // on a collision the write goes first and the read waits one cycle, so
   // it picks up the new word
   assign rd_ready = !stall && !collision;

   assign adv = stage_vld && !stall;

   // --------------------------------------------------------------------------
   // array drive
   // --------------------------------------------------------------------------

   // the enables are the transfer conditions themselves, so the array
   // registers the payload on the same edge the request is accepted
   assign wen   = wr_valid && wr_ready;
   assign wadr  = wr_req.addr;
   assign wdata = wr_req.data;

   assign ren  = rd_valid && rd_ready;
   assign radr = rd_req.addr;

   // --------------------------------------------------------------------------
   // read pipeline and response register
   // --------------------------------------------------------------------------

   // stage flag follows an accepted read, or stays up while stalled
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         stage_vld <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         stage_vld <= ren || stall;
         // loading wins over draining so back-to-back reads stream at one
         // per cycle
         if (adv)
         begin
            rsp_valid <= 1'b1;
         end
         else if (rsp_ready)
         begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // the response word only changes when a new read lands in it
   always_ff @(posedge clk)
   begin
      if (adv)
      begin
         rsp_data <= dout;
      end
   end

   // a held response must survive until it is taken, and the word of a stalled
   // read must not move while it waits, which relies on the array keeping its
   // read address and on writes being held off during the stall
   a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) &&
                                  (!$past(stall) || $stable(dout)))
      else $error("lamb_port_ctrl: held response or stalled read word changed");

endmodule

/* design/lamb_array.sv */
// latch array memory bank
// registers the write and read ports, decodes both addresses to one-hot
// strobes and wordlines, and tiles the rows into latch blocks whose read
// values are ORed into dout

`timescale 1ns/1ps

module lamb_array (
   input  logic              clk,
   input  logic              rst,
   input  logic              wen,
   input  lamb_pkg::addr_t   wadr,
   input  lamb_pkg::data_t   wdata,
   input  logic              ren,
   input  lamb_pkg::addr_t   radr,
   output lamb_pkg::data_t   dout
);

   // registered write port
   lamb_pkg::addr_t wadr_q;
   lamb_pkg::data_t wdata_q;

   // registered read address, it steers the wordlines for a full cycle
   lamb_pkg::addr_t radr_q;

   // set in the cycle after an accepted write, enables the row strobes
   logic wpend;

   // one-hot decodes of the registered addresses
   logic [lamb_pkg::lamb_depth-1:0] wdec;
   logic [lamb_pkg::lamb_depth-1:0] rdec;

   // write strobes after qualification with the pending flag
   logic [lamb_pkg::lamb_depth-1:0] wstb;

   // block read values and their empty flags
   lamb_pkg::data_t blk_y [lamb_pkg::lamb_nblks];
   logic [lamb_pkg::lamb_nblks-1:0] blk_none;

   // --------------------------------------------------------------------------
   // input registers
   // --------------------------------------------------------------------------

   // address and data only move on an accepted request, so a stalled read
   // keeps its row selected
   always_ff @(posedge clk)
   begin
      if (wen)
      begin
         wadr_q  <= wadr;
         wdata_q <= wdata;
      end
      if (ren)
      begin
         radr_q <= radr;
      end
   end

   // without this flag the last written row would be rewritten every cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wpend <= 1'b0;
      end
      else
      begin
         wpend <= wen;
      end
   end

   // --------------------------------------------------------------------------
   // address decode
   // --------------------------------------------------------------------------

   // an address past the last row decodes to no row at all
   assign wdec = {{(lamb_pkg::lamb_depth - 1){1'b0}}, 1'b1} << wadr_q;
   assign rdec = {{(lamb_pkg::lamb_depth - 1){1'b0}}, 1'b1} << radr_q;

   assign wstb = wdec & {lamb_pkg::lamb_depth{wpend}};

   // --------------------------------------------------------------------------
   // block tiling
   // --------------------------------------------------------------------------

   for (genvar b = 0; b < lamb_pkg::lamb_nblks; b++)
   begin : g_blk
      // first row of this block and its row count, the last block is short
      localparam int base  = b * lamb_pkg::lamb_blk_rows;
      localparam int brows = (b == lamb_pkg::lamb_nblks - 1) ?
                             lamb_pkg::lamb_last_rows : lamb_pkg::lamb_blk_rows;

      latch_block #(
         .rows     (brows)
      ) u_blk (
         .clk      (clk),
         .wstb     (wstb[base +: brows]),
         .rwl      (rdec[base +: brows]),
         .wdata    (wdata_q),
         .y        (blk_y[b]),
         .none_sel (blk_none[b])
      );
   end

   // --------------------------------------------------------------------------
   // output merge
   // --------------------------------------------------------------------------

   // only the block holding the read row contributes, the others are
   // masked by their none_sel flag
   always_comb
   begin
      dout = '0;
      for (int b = 0; b < lamb_pkg::lamb_nblks; b++)
      begin
         if (!blk_none[b])
         begin
            dout = dout | blk_y[b];
         end
      end
   end

   // the controller must never pass an address beyond the last row, a write
   // there would be lost and a read would return zero
   a_adr_range: assert property (@(posedge clk) disable iff (rst)
      (!wen || wadr < lamb_pkg::lamb_depth) && (!ren || radr < lamb_pkg::lamb_depth))
      else $error("lamb_array: access beyond row %0d", lamb_pkg::lamb_depth - 1);

endmodule

/* design/latch_block.sv */
// latch block of up to 16 rows
// level-sensitive row storage written through clock-gated strobes, with a
// combinational read that ORs together the rows picked by the wordlines

`timescale 1ns/1ps

module latch_block #(
   parameter int rows = 16
) (
   input  logic              clk,
   input  logic [rows-1:0]   wstb,
   input  logic [rows-1:0]   rwl,
   input  lamb_pkg::data_t   wdata,
   output lamb_pkg::data_t   y,
   output logic              none_sel
);

   // gated row clocks, a row only sees clk while its write strobe is set
   logic [rows-1:0] ck;

   // per-row contribution to the read OR tree
   lamb_pkg::data_t row_y [rows];

   // --------------------------------------------------------------------------
   // write side
   // --------------------------------------------------------------------------

   // the strobe is stable through the whole high phase because the array
   // only changes it on the rising edge
   assign ck = wstb & {rows{clk}};

   for (genvar r = 0; r < rows; r++)
   begin : g_row
      // storage word for this row
      lamb_pkg::data_t q;

      // transparent during the high phase of a strobed cycle, closed on
      // the falling edge so the word is settled before the next rising edge
      always_latch
      begin
         if (ck[r])
         begin
            q <= wdata;
         end
      end

      // a row drives the OR tree only when its wordline is up
      assign row_y[r] = rwl[r] ? q : '0;
   end

   // --------------------------------------------------------------------------
   // read side
   // --------------------------------------------------------------------------

   // wired-OR of all row outputs, at most one of them is non-zero
   always_comb
   begin
      y = '0;
      for (int r = 0; r < rows; r++)
      begin
         y = y | row_y[r];
      end
   end

   // flags a block that is not being read so the array can drop its value
   assign none_sel = ~|rwl;

   // the wordlines come from a one-hot decode in the array, two active rows
   // would short two words onto the same OR tree
   a_rwl_onehot0: assert property (@(posedge clk) $onehot0(rwl))
      else $error("latch_block: more than one read wordline active");

endmodule

/* design/lamb_pkg.sv */
// latch array memory bank shared definitions
// geometry of the 40 x 24 array, its vector types and the request structs

package lamb_pkg;

   // --------------------------------------------------------------------------
   // array geometry
   // --------------------------------------------------------------------------

   // number of rows in the bank
   localparam int lamb_depth = 40;

   // data bits held in each row
   localparam int lamb_width = 24;

   // bits needed to address one row
   localparam int lamb_addr_w = $clog2(lamb_depth);

   // a latch block never holds more than this many rows, which keeps the
   // read wordline OR tree of a block short
   localparam int lamb_blk_rows = 16;

   // number of blocks needed to tile the full depth
   localparam int lamb_nblks = (lamb_depth - 1) / lamb_blk_rows + 1;

   // the last block only takes the rows left over, 8 for a depth of 40
   localparam int lamb_last_rows = lamb_depth - (lamb_nblks - 1) * lamb_blk_rows;

   // --------------------------------------------------------------------------
   // vector types
   // --------------------------------------------------------------------------

   // row address, valid range is 0 to lamb_depth-1
   typedef logic [lamb_addr_w-1:0] addr_t;

   // contents of one row
   typedef logic [lamb_width-1:0] data_t;

   // --------------------------------------------------------------------------
   // request payloads
   // --------------------------------------------------------------------------

   // write request, row address and the word to store there
   typedef struct packed {
      addr_t addr;
      data_t data;
   } wr_req_t;

   // read request, only the row address travels
   typedef struct packed {
      addr_t addr;
   } rd_req_t;

endpackage
